// File: flist.f
rtl/pic_pkg.sv
rtl/irq_sync.sv
rtl/pic.sv
rtl/pic_readback.sv
rtl/pic_top.sv
tests/tb_pic.sv

// File: Bender.yml
package:
  name: pic

sources:
  # Package first, then leaf modules, then the top level
  - rtl/pic_pkg.sv
  - rtl/irq_sync.sv
  - rtl/pic.sv
  - rtl/pic_readback.sv
  - rtl/pic_top.sv
  - target: test
    files:
      - tests/tb_pic.sv

// File: tests/tb_pic.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pic
   import pic_pkg::*;
();

   localparam int TEST_CYCLES     = 2000;             // Rough sum over all tests
   localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;
   localparam int POLL_CYCLES     = 20;               // Line to flush is about 4

   logic            clk = 1'b0;
   logic            nreset;
   logic [IRQW-1:0] ext_irq;
   logic            reg_write;
   logic            reg_read;
   logic [RAW-1:0]  reg_addr;
   logic [LAW-1:0]  reg_wdata;
   wire  [LAW-1:0]  reg_rdata;
   logic [LAW-1:0]  pc_next;
   logic            rti;
   logic            global_irq_en;
   logic            ic_wait;
   wire             flush;
   wire             irq;
   wire  [LAW-1:0]  irq_addr;

   int seed = 24;
   int errors = 0;
   int tests_run = 0;
   int tests_failed = 0;

   always #10 clk = ~clk;   // 20 ns period

   pic_top pic_top_i (
      .clk           (clk),
      .nreset        (nreset),
      .ext_irq       (ext_irq),
      .reg_write     (reg_write),
      .reg_read      (reg_read),
      .reg_addr      (reg_addr),
      .reg_wdata     (reg_wdata),
      .reg_rdata     (reg_rdata),
      .pc_next       (pc_next),
      .rti           (rti),
      .global_irq_en (global_irq_en),
      .ic_wait       (ic_wait),
      .flush         (flush),
      .irq           (irq),
      .irq_addr      (irq_addr)
   );

   // ##########################################################
   // Reference model
   // ##########################################################
   // Line that gets flushed, or -1
   function automatic int select_line(input logic [IRQW-1:0] lat, input logic [IRQW-1:0] msk,
                                      input logic [IRQW-1:0] pend, input logic gen);
      int   k;
      logic blocked;
      k = -1;
      blocked = !gen;
      for (int j = IRQW-1; j >= 0; j--)
      begin
         if (lat[j] && !msk[j])
            k = j;   // Lowest unmasked request
      end
      for (int j = 0; j < IRQW; j++)
      begin
         if (pend[j] && j <= k)
            blocked = 1'b1;   // Same or higher priority in service
      end
      if (blocked)
         k = -1;
      return k;
   endfunction

   function automatic logic [LAW-1:0] vector_of(input int k);
      return IVT_BASE + 4 * k;
   endfunction

   // Innermost routine returns first
   function automatic logic [IRQW-1:0] unwind(input logic [IRQW-1:0] pend);
      return pend & (pend - 1'b1);
   endfunction

   // ##########################################################
   // Checks and bus helpers
   // ##########################################################
   task automatic check_val(input string name, input logic [LAW-1:0] got,
                            input logic [LAW-1:0] exp);
      assert (got === exp)
      else
      begin
         $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   task automatic check_cond(input logic ok, input string what);
      assert (ok)
      else
      begin
         $display("Failure at %0t: %s", $time, what);
         errors++;
      end
   endtask

   // All bus tasks start and end on a falling edge
   task automatic write_reg(input logic [RAW-1:0] addr, input logic [LAW-1:0] data);
      reg_write = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(negedge clk);
      reg_write = 1'b0;
   endtask

   task automatic read_check(input logic [RAW-1:0] addr, input logic [LAW-1:0] exp,
                             input string name);
      reg_read = 1'b1;
      reg_addr = addr;
      @(negedge clk);
      reg_read = 1'b0;
      check_val(name, reg_rdata, exp);   // Captured at the rising edge just passed
   endtask

   task automatic pulse_rti();
      rti = 1'b1;
      @(negedge clk);
      rti = 1'b0;
   endtask

   task automatic wait_flush(input int line);
      int n;
      n = 0;
      while (!flush && n < POLL_CYCLES)   // Current cycle counts too
      begin
         @(negedge clk);
         n++;
      end
      check_cond(flush, $sformatf("interrupt never arrived on line %0d", line));
   endtask

   task automatic expect_entry(input int line);
      wait_flush(line);
      if (flush)
      begin
         @(negedge clk);
         check_val("irq", irq, 1);
         check_val("irq_addr", irq_addr, vector_of(line));
         check_val("flush", flush, 0);   // One cycle only
         @(negedge clk);                 // Entry taken, IPEND set
         check_val("irq", irq, 0);
      end
   endtask

   task automatic expect_quiet(input int cycles);
      repeat (cycles)
      begin
         check_val("flush", flush, 0);
         check_val("irq", irq, 0);
         @(negedge clk);
      end
   endtask

   task automatic follow_model(input logic [IRQW-1:0] lat, input logic [IRQW-1:0] msk,
                               input logic [IRQW-1:0] pend, input logic gen);
      int k;
      k = select_line(lat, msk, pend, gen);
      if (k < 0)
         expect_quiet(8);
      else
         expect_entry(k);
   endtask

   // Lines low long enough to rearm the edge detector
   task automatic clear_state();
      global_irq_en = 1'b0;
      ic_wait       = 1'b0;
      ext_irq       = '0;
      repeat (4) @(negedge clk);
      write_reg(REG_ILAT, '0);
      write_reg(REG_IPEND, '0);
      write_reg(REG_IMASK, '0);
   endtask

   task automatic finish_test(input string name, input int start);
      tests_run++;
      if (errors > start)
      begin
         tests_failed++;
         $display("Test %s: failed with %0d errors", name, errors - start);
      end
      else
         $display("Test %s: ok", name);
   endtask

   // ##########################################################
   // Tests
   // ##########################################################
   task automatic test_registers();
      int              start;
      logic [IRQW-1:0] mask_v;
      logic [IRQW-1:0] pend_v;
      logic [IRQW-1:0] set_v;
      logic [IRQW-1:0] clr_v;
      logic [LAW-1:0]  iret_v;
      start  = errors;
      mask_v = IRQW'($random(seed));
      pend_v = IRQW'($random(seed));
      set_v  = IRQW'($random(seed));
      clr_v  = IRQW'($random(seed));
      iret_v = $random(seed);
      write_reg(REG_IMASK, LAW'(mask_v));
      write_reg(REG_IRET, iret_v);
      write_reg(REG_IPEND, LAW'(pend_v));
      write_reg(REG_ILATST, LAW'(set_v));   // ILAT starts at zero
      write_reg(REG_ILATCL, LAW'(clr_v));
      read_check(REG_IMASK, LAW'(mask_v), "IMASK");
      read_check(REG_IRET, iret_v, "IRET");
      read_check(REG_IPEND, LAW'(pend_v), "IPEND");
      read_check(REG_ILAT, LAW'(set_v & ~clr_v), "ILAT");
      read_check(REG_ILATST, LAW'(set_v & ~clr_v), "ILATST alias");
      read_check(REG_ILATCL, LAW'(set_v & ~clr_v), "ILATCL alias");
      read_check(6'h3F, '0, "unmapped");
      clear_state();
      finish_test("register access", start);
   endtask

   task automatic test_single();
      int             start;
      int             line;
      logic [LAW-1:0] pc;
      start = errors;
      line  = $unsigned($random(seed)) % IRQW;
      pc    = $random(seed);
      pc_next       = pc;   // Held through the flush cycle
      global_irq_en = 1'b1;
      ext_irq[line] = 1'b1;
      follow_model(IRQW'(1 << line), '0, '0, 1'b1);
      read_check(REG_IRET, pc, "IRET");
      read_check(REG_ILAT, '0, "ILAT");
      read_check(REG_IPEND, 1 << line, "IPEND");
      clear_state();
      finish_test("single interrupt", start);
   endtask

   task automatic test_two_lines();
      int              start;
      int              a;
      int              b;
      logic [IRQW-1:0] both;
      start = errors;
      a    = $unsigned($random(seed)) % (IRQW - 1);
      b    = a + 1 + $unsigned($random(seed)) % (IRQW - 1 - a);
      both = IRQW'((1 << a) | (1 << b));
      global_irq_en = 1'b1;
      ext_irq       = both;
      follow_model(both, '0, '0, 1'b1);           // Lower index first
      clear_state();
      write_reg(REG_IMASK, 1 << a);
      global_irq_en = 1'b1;
      ext_irq       = both;
      follow_model(both, IRQW'(1 << a), '0, 1'b1);   // Masked, so b
      clear_state();
      ext_irq = both;                             // Enable stays low
      follow_model(both, '0, '0, 1'b0);
      read_check(REG_ILAT, LAW'(both), "ILAT");
      clear_state();
      finish_test("simultaneous lines and masking", start);
   endtask

   task automatic test_nesting();
      int              start;
      logic [IRQW-1:0] lat;
      logic [IRQW-1:0] pend;
      start = errors;
      global_irq_en = 1'b1;
      ext_irq[5]    = 1'b1;
      follow_model(IRQW'(1 << 5), '0, '0, 1'b1);
      pend = IRQW'(1 << 5);
      lat  = '0;
      ext_irq[7] = 1'b1;
      lat = lat | IRQW'(1 << 7);
      follow_model(lat, '0, pend, 1'b1);   // Lower priority, blocked
      ext_irq[2] = 1'b1;
      lat = lat | IRQW'(1 << 2);
      follow_model(lat, '0, pend, 1'b1);   // Nests above 5
      pend = pend | IRQW'(1 << 2);
      lat  = lat & ~IRQW'(1 << 2);
      pulse_rti();
      pend = unwind(pend);
      read_check(REG_IPEND, LAW'(pend), "IPEND after first rti");
      follow_model(lat, '0, pend, 1'b1);
      pulse_rti();
      pend = unwind(pend);
      follow_model(lat, '0, pend, 1'b1);   // Now 7 gets in
      read_check(REG_IPEND, 1 << 7, "IPEND after second rti");
      clear_state();
      finish_test("nesting", start);
   endtask

   task automatic test_wait_hold();
      int start;
      int line;
      start = errors;
      line  = $unsigned($random(seed)) % IRQW;
      global_irq_en = 1'b1;
      ic_wait       = 1'b1;
      ext_irq[line] = 1'b1;
      wait_flush(line);
      repeat (5)
      begin
         check_val("irq", irq, 0);     // Entry frozen
         check_val("flush", flush, 1);
         @(negedge clk);
      end
      read_check(REG_ILAT, 1 << line, "ILAT while waiting");
      ic_wait = 1'b0;
      @(negedge clk);
      check_val("irq", irq, 1);
      check_val("irq_addr", irq_addr, vector_of(line));
      read_check(REG_ILAT, 1 << line, "ILAT at entry");   // Clears at this edge
      read_check(REG_ILAT, '0, "ILAT after entry");
      read_check(REG_IPEND, 1 << line, "IPEND");
      clear_state();
      finish_test("wait hold", start);
   endtask

   // ##########################################################
   // Sequence and watchdog
   // ##########################################################
   initial
   begin
      nreset        = 1'b0;
      ext_irq       = '0;
      reg_write     = 1'b0;
      reg_read      = 1'b0;
      reg_addr      = '0;
      reg_wdata     = '0;
      pc_next       = '0;
      rti           = 1'b0;
      global_irq_en = 1'b0;
      ic_wait       = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      @(negedge clk);
      test_registers();
      test_single();
      test_two_lines();
      test_nesting();
      test_wait_hold();
      $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Run stopped, still busy after %0d cycles", WATCHDOG_CYCLES);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/pic_top.sv
`timescale 1ns/1ps
`default_nettype none

// Interrupt controller with input sync and register readback
module pic_top
   import pic_pkg::*;
(
   input  wire              clk,
   input  wire              nreset,
   input  wire  [IRQW-1:0]  ext_irq,        // Asynchronous lines
   // Register port
   input  wire              reg_write,
   input  wire              reg_read,
   input  wire  [RAW-1:0]   reg_addr,
   input  wire  [LAW-1:0]   reg_wdata,
   output logic [LAW-1:0]   reg_rdata,
   // Core side
   input  wire  [LAW-1:0]   pc_next,
   input  wire              rti,
   input  wire              global_irq_en,
   input  wire              ic_wait,
   output logic             flush,
   output logic             irq,
   output logic [LAW-1:0]   irq_addr
);

   logic [IRQW-1:0] irq_sync_q;   // Lines in clk domain
   logic [LAW-1:0]  iret_reg;
   logic [IRQW-1:0] imask_reg;
   logic [IRQW-1:0] ilat_reg;
   logic [IRQW-1:0] ipend_reg;

   irq_sync irq_sync_i (
      .clk        (clk),
      .nreset     (nreset),
      .irq_async  (ext_irq),
      .irq_sync_q (irq_sync_q)
   );

   pic pic_i (
      .clk           (clk),
      .nreset        (nreset),
      .reg_write     (reg_write),
      .reg_addr      (reg_addr),
      .reg_wdata     (reg_wdata),
      .ext_irq       (irq_sync_q),
      .pc_next       (pc_next),
      .rti           (rti),
      .global_irq_en (global_irq_en),
      .ic_wait       (ic_wait),
      .flush         (flush),
      .irq           (irq),
      .irq_addr      (irq_addr),
      .iret_reg      (iret_reg),
      .imask_reg     (imask_reg),
      .ilat_reg      (ilat_reg),
      .ipend_reg     (ipend_reg)
   );

   // Shares reg_addr with the write side
   pic_readback pic_readback_i (
      .clk       (clk),
      .nreset    (nreset),
      .reg_read  (reg_read),
      .reg_addr  (reg_addr),
      .iret_reg  (iret_reg),
      .imask_reg (imask_reg),
      .ilat_reg  (ilat_reg),
      .ipend_reg (ipend_reg),
      .reg_rdata (reg_rdata)
   );

endmodule

`default_nettype wire

// File: rtl/pic_readback.sv
`timescale 1ns/1ps
`default_nettype none

// Register read mux with a registered result
module pic_readback
   import pic_pkg::*;
(
   input  wire              clk,
   input  wire              nreset,
   input  wire              reg_read,     // Read strobe
   input  wire  [RAW-1:0]   reg_addr,
   input  wire  [LAW-1:0]   iret_reg,
   input  wire  [IRQW-1:0]  imask_reg,
   input  wire  [IRQW-1:0]  ilat_reg,
   input  wire  [IRQW-1:0]  ipend_reg,
   output logic [LAW-1:0]   reg_rdata     // Valid the cycle after the read
);

   logic [LAW-1:0] rdata_mux;

   // Narrow registers padded with zeros
   always_comb
   begin
      case (reg_addr)
         REG_IRET   : rdata_mux = iret_reg;
         REG_IMASK  : rdata_mux = {{(LAW-IRQW){1'b0}}, imask_reg};
         REG_ILAT,
         REG_ILATST,
         REG_ILATCL : rdata_mux = {{(LAW-IRQW){1'b0}}, ilat_reg};   // Set/clear alias ILAT
         REG_IPEND  : rdata_mux = {{(LAW-IRQW){1'b0}}, ipend_reg};
         default    : rdata_mux = '0;   // Unmapped
      endcase
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         reg_rdata <= '0;
      else if (reg_read)
         reg_rdata <= rdata_mux;
   end

   // Data only moves on a read
   a_rdata_hold: assert property (
      @(posedge clk) disable iff (!nreset) !reg_read |=> $stable(reg_rdata)
   );

endmodule

`default_nettype wire

// File: rtl/pic.sv
`timescale 1ns/1ps
`default_nettype none

// Nested interrupt controller with fixed priority, bit 0 highest
module pic
   import pic_pkg::*;
(
   input  wire              clk,
   input  wire              nreset,
   // Register write port
   input  wire              reg_write,
   input  wire  [RAW-1:0]   reg_addr,
   input  wire  [LAW-1:0]   reg_wdata,
   // Core side
   input  wire  [IRQW-1:0]  ext_irq,         // Already synchronized
   input  wire  [LAW-1:0]   pc_next,         // PC saved into IRET
   input  wire              rti,             // Return from interrupt
   input  wire              global_irq_en,
   input  wire              ic_wait,         // Core not ready to be interrupted
   output logic             flush,           // Pipeline flush pulse
   output logic             irq,             // Jump request
   output logic [LAW-1:0]   irq_addr,        // Valid while irq high
   // Register values for readback
   output logic [LAW-1:0]   iret_reg,
   output logic [IRQW-1:0]  imask_reg,
   output logic [IRQW-1:0]  ilat_reg,
   output logic [IRQW-1:0]  ipend_reg
);

   logic             wr_ilat;
   logic             wr_ilatst;
   logic             wr_ilatcl;
   logic             wr_imask;
   logic             wr_ipend;
   logic             wr_iret;

   logic [IRQW-1:0]  irq_shadow;     // Last cycle's lines
   logic [IRQW-1:0]  irq_event;      // Rising edges
   logic [IRQW-1:0]  ilat_next;
   logic [IRQW-1:0]  entry;          // Line being handed to the core
   logic [IRQW-1:0]  entry_take;     // Entry accepted this cycle
   logic [IRQW-1:0]  rti_clr;        // Lowest set IPEND bit
   logic [IRQW-1:0]  ipend_next;
   logic [IRQW-1:0]  masked_ilat;
   logic [IRQW-1:0]  ilat_prio_n;    // Some lower unmasked ILAT bit set
   logic [IRQW-1:0]  ipend_prio_n;   // Some IPEND bit at or below set
   logic [IRQW-1:0]  irq_select;
   logic [LAW-1:0]   ivt [IRQW];     // Vector table

   // #########################################################
   // Write decode
   // #########################################################
   assign wr_ilat   = reg_write && (reg_addr == REG_ILAT);
   assign wr_ilatst = reg_write && (reg_addr == REG_ILATST);
   assign wr_ilatcl = reg_write && (reg_addr == REG_ILATCL);
   assign wr_imask  = reg_write && (reg_addr == REG_IMASK);
   assign wr_ipend  = reg_write && (reg_addr == REG_IPEND);
   assign wr_iret   = reg_write && (reg_addr == REG_IRET);

   // #########################################################
   // Edge detection and ILAT
   // #########################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         irq_shadow <= '0;
      else
         irq_shadow <= ext_irq;
   end

   assign irq_event = ext_irq & ~irq_shadow;   // Low to high only

   // Core took the entry only when it was not waiting
   assign entry_take = entry & {IRQW{~ic_wait}};

   always_comb
   begin
      if (wr_ilat)
         ilat_next = reg_wdata[IRQW-1:0];
      else if (wr_ilatst)
         ilat_next = ilat_reg | reg_wdata[IRQW-1:0];
      else if (wr_ilatcl)
         ilat_next = ilat_reg & ~reg_wdata[IRQW-1:0];
      else
         ilat_next = ilat_reg & ~entry_take;   // Served request drops
      // An edge is never lost, not even to a software write
      ilat_next = ilat_next | irq_event;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         ilat_reg <= '0;
      else
         ilat_reg <= ilat_next;
   end

   // #########################################################
   // IPEND
   // #########################################################
   // Innermost routine is the lowest set bit
   always_comb
   begin
      rti_clr[0] = ipend_reg[0];
      for (int i = 1; i < IRQW; i++)
         rti_clr[i] = ipend_reg[i] & ~ipend_prio_n[i-1];
   end

   // One nesting level unwinds per rti
   assign ipend_next = (ipend_reg & ~(rti_clr & {IRQW{rti}})) | entry_take;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         ipend_reg <= '0;
      else if (wr_ipend)
         ipend_reg <= reg_wdata[IRQW-1:0];
      else
         ipend_reg <= ipend_next;
   end

   // #########################################################
   // IMASK
   // #########################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         imask_reg <= '0;
      else if (wr_imask)
         imask_reg <= reg_wdata[IRQW-1:0];
   end

   // #########################################################
   // IRET
   // #########################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         iret_reg <= '0;
      else if (wr_iret)
         iret_reg <= reg_wdata;   // Software restore wins
      else if (flush)
         iret_reg <= pc_next;
   end

   // Arbitration
   // Vector per line from the table base
   for (genvar k = 0; k < IRQW; k++)
   begin : g_ivt
      assign ivt[k] = IVT_BASE + IVT_STRIDE * k;
   end

   assign masked_ilat = ilat_reg & ~imask_reg;

   // Both priority chains walk up from bit 0
   always_comb
   begin
      ilat_prio_n[0]  = 1'b0;             // Nothing outranks bit 0
      ipend_prio_n[0] = ipend_reg[0];
      for (int i = 1; i < IRQW; i++)
      begin
         ilat_prio_n[i]  = ilat_prio_n[i-1] | masked_ilat[i-1];
         ipend_prio_n[i] = ipend_prio_n[i-1] | ipend_reg[i];
      end
   end

   // No new pick while an entry is out so flush stays one cycle
   assign irq_select = masked_ilat & ~ilat_prio_n & ~ipend_prio_n
                     & {IRQW{global_irq_en}} & {IRQW{~irq}};

   assign flush = |irq_select;

   // Entry freezes while the core waits
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         entry <= '0;
      else if (!ic_wait)
         entry <= irq_select;
   end

   assign irq = |entry;

   always_comb
   begin
      irq_addr = '0;
      for (int p = 0; p < IRQW; p++)
         irq_addr = irq_addr | ({LAW{entry[p]}} & ivt[p]);   // At most one hit
   end

   // Checks
   a_entry_onehot: assert property (
      @(posedge clk) disable iff (!nreset) $onehot0(entry)
   );

   // Top priority routine in service blocks everything
   a_no_flush_ipend0: assert property (
      @(posedge clk) disable iff (!nreset) ipend_reg[0] |-> !flush
   );

   a_ilat_known: assert property (
      @(posedge clk) disable iff (!nreset) !$isunknown(ilat_reg)
   );

endmodule

`default_nettype wire

// File: rtl/irq_sync.sv
`timescale 1ns/1ps
`default_nettype none

// Brings the external interrupt levels into the clk domain
module irq_sync
   import pic_pkg::*;
(
   input  wire              clk,
   input  wire              nreset,
   input  wire  [IRQW-1:0]  irq_async,    // Raw lines from the pads
   output logic [IRQW-1:0]  irq_sync_q    // Safe to use in clk domain
);

   logic [IRQW-1:0] meta_q;   // First stage, may go metastable

   // Two flops per line
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         meta_q     <= '0;
         irq_sync_q <= '0;
      end
      else
      begin
         meta_q     <= irq_async;
         irq_sync_q <= meta_q;   // Settled copy
      end
   end

endmodule

`default_nettype wire

// File: rtl/pic_pkg.sv
`default_nettype none

package pic_pkg;

   // #########################################################
   // Sizes
   // #########################################################
   localparam int IRQW = 10;   // Interrupt lines
   localparam int LAW  = 32;   // Address and data width
   localparam int RAW  = 6;    // Register address width

   // #########################################################
   // Register map
   // #########################################################
   // Six word slots in the system register space
   localparam logic [RAW-1:0] REG_IRET   = 6'h08;   // Return PC
   localparam logic [RAW-1:0] REG_IMASK  = 6'h09;   // Mask, 1 blocks the line
   localparam logic [RAW-1:0] REG_ILAT   = 6'h0A;   // Latched requests
   localparam logic [RAW-1:0] REG_ILATST = 6'h0B;   // OR into ILAT
   localparam logic [RAW-1:0] REG_ILATCL = 6'h0C;   // Clear bits of ILAT
   localparam logic [RAW-1:0] REG_IPEND  = 6'h0D;   // Routines in service

   // #########################################################
   // Vector table
   // #########################################################
   // Line k jumps to IVT_BASE + IVT_STRIDE*k
   localparam logic [LAW-1:0] IVT_BASE   = 32'h0000_0040;
   localparam logic [LAW-1:0] IVT_STRIDE = 32'd4;   // One word per entry

endpackage

`default_nettype wire
